// ==== design/bch_pkg.sv ====
package bch_pkg;

	// BCH(15,11) over GF(16)
	localparam int bch_n = 15;
	localparam int bch_k = 11;
	localparam int bch_m = 4;
	localparam int bch_ecc_bits = 4;
	localparam int bch_cnt_w = 4;
	localparam int bch_err_w = 2;
	localparam int expect_depth = 4;

	// x^4 + x + 1 with the leading term dropped
	localparam logic [bch_m-1:0] bch_poly_low = 4'b0011;

	function automatic logic [bch_m-1:0] gf_mul_alpha(input logic [bch_m-1:0] a);
		return {a[bch_m-2:0], 1'b0} ^ (a[bch_m-1] ? bch_poly_low : '0);
	endfunction

	function automatic logic [bch_m-1:0] gf_mul_alpha_inv(input logic [bch_m-1:0] a);
		if (a[0])
			return ((a ^ bch_poly_low) >> 1) | {1'b1, {(bch_m-1){1'b0}}};
		return a >> 1;
	endfunction

	function automatic logic [bch_m-1:0] gf_alpha_pow(input int unsigned p);
		logic [bch_m-1:0] a;
		a = {{(bch_m-1){1'b0}}, 1'b1};
		for (int i = 0; i < bch_n; i++) begin
			if (i < p % bch_n)
				a = gf_mul_alpha(a);
		end
		return a;
	endfunction

	typedef struct packed {
		logic [bch_n-1:0] err_pattern;
		logic [bch_err_w-1:0] err_count;
	} expect_t;

	typedef struct packed {
		logic valid;
		logic [bch_k-1:0] data;
		logic [bch_err_w-1:0] err_count;
		logic errors_present;
	} result_t;

	typedef enum logic {
		loc_idle,
		loc_emit
	} locate_state_t;

endpackage

// ==== design/bch_encode.sv ====
module bch_encode import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [bch_k-1:0] data_in,
	output logic ready,
	output logic code_bit,
	output logic first,
	output logic last
);

	logic busy;
	logic [bch_cnt_w-1:0] cnt;
	logic [bch_k-1:0] data_sr;
	logic [bch_ecc_bits-1:0] rem;
	logic data_phase;
	logic feedback;
	logic accept;

	assign data_phase = cnt < bch_cnt_w'(bch_k);
	assign feedback = data_sr[bch_k-1] ^ rem[bch_ecc_bits-1];

	// Data bits first, then the remainder as parity
	assign code_bit = data_phase ? data_sr[bch_k-1] : rem[bch_ecc_bits-1];
	assign first = busy && cnt == '0;
	assign last = busy && cnt == bch_cnt_w'(bch_n - 1);
	assign ready = !busy || last;
	assign accept = start && ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (last)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			data_sr <= data_in;
			rem <= '0;
		end else if (busy) begin
			data_sr <= data_sr << 1;
			// Divide by the generator while data goes out
			if (data_phase)
				rem <= {rem[bch_ecc_bits-2:0], 1'b0} ^ (feedback ? bch_poly_low : '0);
			else
				rem <= rem << 1;
		end
	end

endmodule

// ==== design/bch_syndrome.sv ====
module bch_syndrome import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic bit_in,
	output logic [bch_m-1:0] syndrome,
	output logic done
);

	logic active;
	logic [bch_cnt_w-1:0] cnt;
	logic [bch_m-1:0] acc;
	logic [bch_m-1:0] acc_next;
	logic final_bit;

	// Horner step for r(alpha), highest bit first
	assign acc_next = gf_mul_alpha(acc) ^ {{(bch_m-1){1'b0}}, bit_in};
	assign final_bit = active && cnt == bch_cnt_w'(bch_n - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			active <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= final_bit;
			if (start) begin
				active <= 1'b1;
				cnt <= bch_cnt_w'(1);
			end else if (active) begin
				cnt <= cnt + 1'b1;
				if (final_bit)
					active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			acc <= {{(bch_m-1){1'b0}}, bit_in};
		else if (active)
			acc <= acc_next;

		// Held so the next word can start right away
		if (final_bit)
			syndrome <= acc_next;
	end

endmodule

// ==== design/bch_error_locate.sv ====
module bch_error_locate import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [bch_m-1:0] syndrome,
	output logic err_bit,
	output logic valid,
	output logic first,
	output logic last,
	output logic [bch_err_w-1:0] err_count,
	output logic errors_present
);

	locate_state_t state;
	logic [bch_cnt_w-1:0] cnt;
	logic [bch_m-1:0] syn_q;
	logic [bch_m-1:0] chien;

	assign valid = state == loc_emit;
	assign first = valid && cnt == '0;
	assign last = valid && cnt == bch_cnt_w'(bch_n - 1);

	// A single error at position i gives S1 = alpha^i
	assign err_bit = valid && chien == syn_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= loc_idle;
			cnt <= '0;
			err_count <= '0;
			errors_present <= 1'b0;
		end else begin
			case (state)
				loc_idle: begin
					if (start) begin
						state <= loc_emit;
						cnt <= '0;
					end
				end
				loc_emit: begin
					cnt <= cnt + 1'b1;
					if (start)
						cnt <= '0;
					else if (last)
						state <= loc_idle;
				end
				default: state <= loc_idle;
			endcase
			if (start) begin
				errors_present <= |syndrome;
				err_count <= (|syndrome) ? bch_err_w'(1) : '0;
			end
		end
	end

	// Walk positions from 14 down to 0
	always_ff @(posedge clk) begin
		if (start) begin
			syn_q <= syndrome;
			chien <= gf_alpha_pow(bch_n - 1);
		end else if (valid) begin
			chien <= gf_mul_alpha_inv(chien);
		end
	end

endmodule

// ==== design/bch_expect_fifo.sv ====
module bch_expect_fifo import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic push,
	input expect_t push_data,
	input logic pop,
	output expect_t pop_data,
	output logic overflow
);

	expect_t mem [expect_depth];
	logic [$clog2(expect_depth)-1:0] wr_ptr;
	logic [$clog2(expect_depth)-1:0] rd_ptr;
	logic [$clog2(expect_depth+1)-1:0] count;
	logic full;
	logic empty;
	logic do_push;
	logic do_pop;

	assign full = count == ($clog2(expect_depth+1))'(expect_depth);
	assign empty = count == '0;
	assign do_pop = pop && !empty;
	// A pop in the same cycle frees a slot
	assign do_push = push && (!full || pop);

	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			overflow <= push && !do_push;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

// ==== design/bch_loop_check.sv ====
module bch_loop_check import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [bch_k-1:0] data_in,
	input logic [bch_n-1:0] error,
	input logic encode_start,
	output logic ready,
	output result_t result,
	output logic wrong
);

	logic accepted;
	logic enc_bit;
	logic enc_first;
	logic rx_bit;
	logic [bch_m-1:0] syndrome;
	logic syn_done;
	logic err_bit;
	logic err_valid;
	logic err_first;
	logic err_last;
	logic [bch_err_w-1:0] loc_count;
	logic loc_present;
	expect_t push_data;
	expect_t pop_data;
	logic overflow;
	logic mismatch;

	logic [bch_n-1:0] err_sr;
	logic [bch_n-1:0] rx_shift;
	logic [bch_n-1:0] rx_hold;
	logic [bch_n-1:0] corr_sr;
	logic [bch_n-1:0] loc_sr;
	logic [bch_err_w-1:0] count_q;
	logic present_q;
	logic res_valid;

	// Number of flipped bits, saturated at two
	function automatic logic [bch_err_w-1:0] err_weight(input logic [bch_n-1:0] e);
		int ones;
		ones = 0;
		for (int i = 0; i < bch_n; i++)
			ones += e[i];
		return (ones > 2) ? bch_err_w'(2) : bch_err_w'(ones);
	endfunction

	assign accepted = encode_start && ready;
	assign push_data = '{err_pattern: error, err_count: err_weight(error)};
	assign rx_bit = enc_bit ^ err_sr[bch_n-1];

	bch_encode u_encode (
		.clk(clk),
		.reset(reset),
		.start(encode_start),
		.data_in(data_in),
		.ready(ready),
		.code_bit(enc_bit),
		.first(enc_first),
		.last()
	);

	bch_syndrome u_syndrome (
		.clk(clk),
		.reset(reset),
		.start(enc_first),
		.bit_in(rx_bit),
		.syndrome(syndrome),
		.done(syn_done)
	);

	bch_error_locate u_locate (
		.clk(clk),
		.reset(reset),
		.start(syn_done),
		.syndrome(syndrome),
		.err_bit(err_bit),
		.valid(err_valid),
		.first(err_first),
		.last(err_last),
		.err_count(loc_count),
		.errors_present(loc_present)
	);

	bch_expect_fifo u_expect (
		.clk(clk),
		.reset(reset),
		.push(accepted),
		.push_data(push_data),
		.pop(res_valid),
		.pop_data(pop_data),
		.overflow(overflow)
	);

	always_ff @(posedge clk) begin
		if (accepted)
			err_sr <= error;
		else
			err_sr <= err_sr << 1;

		rx_shift <= {rx_shift[bch_n-2:0], rx_bit};

		// Next word lands here while the locator walks this one
		if (syn_done)
			rx_hold <= rx_shift;
		else if (err_valid)
			rx_hold <= rx_hold << 1;

		if (err_valid) begin
			corr_sr <= {corr_sr[bch_n-2:0], rx_hold[bch_n-1] ^ err_bit};
			loc_sr <= {loc_sr[bch_n-2:0], err_bit};
		end

		if (err_first) begin
			count_q <= loc_count;
			present_q <= loc_present;
		end
	end

	assign result = '{
		valid: res_valid,
		data: corr_sr[bch_n-1:bch_ecc_bits],
		err_count: count_q,
		errors_present: present_q
	};

	assign mismatch = res_valid &&
		(loc_sr != pop_data.err_pattern || count_q != pop_data.err_count);

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			wrong <= 1'b0;
		end else begin
			res_valid <= err_last;
			if (mismatch || overflow)
				wrong <= 1'b1;
		end
	end

endmodule

// ==== testbench/bch_loop_check_tb.sv ====
module bch_loop_check_tb import bch_pkg::*; ();

	localparam int num_entries = 35;
	localparam int timeout_cycles = num_entries * 40 + 100;
	localparam logic [31:0] lfsr_seed = 32'hd3ab_ab34;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	typedef struct packed {
		logic rand_data;
		logic [bch_k-1:0] data;
		logic [bch_n-1:0] error;
		logic expect_wrong;
	} entry_t;

	logic clk;
	logic reset;
	logic [bch_k-1:0] data_in;
	logic [bch_n-1:0] error;
	logic encode_start;
	logic ready;
	result_t result;
	logic wrong;

	entry_t table_e [num_entries];
	entry_t sent_q [$];
	logic [31:0] lfsr;
	int results_seen;
	logic wrong_expected;

	bch_loop_check bch_loop_check_i (
		.clk(clk),
		.reset(reset),
		.data_in(data_in),
		.error(error),
		.encode_start(encode_start),
		.ready(ready),
		.result(result),
		.wrong(wrong)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
	endfunction

	// One LFSR step per data bit
	function automatic logic [bch_k-1:0] random_word();
		logic [bch_k-1:0] w;
		w = '0;
		for (int b = 0; b < bch_k; b++) begin
			lfsr = lfsr_step(lfsr);
			w = {w[bch_k-2:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic entry_t make_entry(input logic rand_data, input logic [bch_k-1:0] data,
			input logic [bch_n-1:0] err, input logic expect_wrong);
		entry_t e;
		e.rand_data = rand_data;
		e.data = data;
		e.error = err;
		e.expect_wrong = expect_wrong;
		return e;
	endfunction

	task automatic fill_table();
		table_e[0] = make_entry(1'b0, 11'h5a3, '0, 1'b0);
		table_e[1] = make_entry(1'b0, 11'h7ff, '0, 1'b0);
		table_e[2] = make_entry(1'b0, 11'h000, '0, 1'b0);
		// Single flipped bit at every position, fixed then random data
		for (int i = 0; i < bch_n; i++) begin
			table_e[3 + i] = make_entry(1'b0, 11'h2c6 ^ bch_k'(i * 37), bch_n'(1) << i, 1'b0);
			table_e[18 + i] = make_entry(1'b1, '0, bch_n'(1) << i, 1'b0);
		end
		table_e[33] = make_entry(1'b1, '0, '0, 1'b0);
		// Two flipped bits, beyond what the code corrects
		table_e[34] = make_entry(1'b0, 11'h31d, 15'h0208, 1'b1);
	endtask

	// Holds the start until the DUT was ready in the cycle it was presented
	task automatic send_word(input entry_t e);
		entry_t applied;
		applied = e;
		if (e.rand_data)
			applied.data = random_word();
		data_in <= applied.data;
		error <= applied.error;
		encode_start <= 1'b1;
		@(posedge clk);
		while (!ready)
			@(posedge clk);
		sent_q.push_back(applied);
	endtask

	task automatic check_result();
		entry_t exp;
		logic [bch_err_w-1:0] exp_count;
		logic exp_present;
		assert (sent_q.size() > 0)
			else report_failure("a result arrived with no word outstanding");
		exp = sent_q.pop_front();
		exp_present = |exp.error;
		// Any nonzero syndrome points at exactly one position
		exp_count = exp_present ? bch_err_w'(1) : '0;
		assert (result.err_count == exp_count)
			else report_value("result.err_count", 32'(result.err_count), 32'(exp_count));
		assert (result.errors_present == exp_present)
			else report_value("result.errors_present", 32'(result.errors_present),
				32'(exp_present));
		if (!exp.expect_wrong) begin
			assert (result.data == exp.data)
				else report_value("result.data", 32'(result.data), 32'(exp.data));
		end
		assert (wrong == wrong_expected)
			else report_value("wrong", 32'(wrong), 32'(wrong_expected));
		if (exp.expect_wrong)
			wrong_expected = 1'b1;
		results_seen++;
	endtask

	always @(negedge clk) begin
		if (!reset && result.valid)
			check_result();
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		report_failure("timeout while waiting for results");
	end

	initial begin
		reset = 1'b1;
		data_in = '0;
		error = '0;
		encode_start = 1'b0;
		lfsr = lfsr_seed;
		results_seen = 0;
		wrong_expected = 1'b0;
		fill_table();
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		for (int i = 0; i < num_entries; i++)
			send_word(table_e[i]);
		encode_start <= 1'b0;

		while (results_seen < num_entries)
			@(posedge clk);
		// Idle time so a duplicated result would still show up
		repeat (40) @(posedge clk);
		@(negedge clk);

		if (wrong) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			report_failure("wrong flag did not rise on a double error");
		end
	end

endmodule

// ==== compile.f ====
design/bch_pkg.sv
design/bch_encode.sv
design/bch_syndrome.sv
design/bch_error_locate.sv
design/bch_expect_fifo.sv
design/bch_loop_check.sv
testbench/bch_loop_check_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the BCH loopback testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module bch_loop_check_tb --Mdir obj_dir -o bch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/bch_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation finished: PASS" sim.log; then
	exit 0
fi
echo "No pass line found in sim.log"
exit 1
